/* flist.f */
+incdir+tb
hdl/cpu_pkg.sv
hdl/alu.sv
hdl/register_file.sv
hdl/cpu_control.sv
hdl/monitor_memory.sv
hdl/cpu_system.sv
tb/cpu_system_tb.sv

/* Bender.yml */
package:
  name: cpu_system

sources:
  - hdl/cpu_pkg.sv
  - hdl/alu.sv
  - hdl/register_file.sv
  - hdl/cpu_control.sv
  - hdl/monitor_memory.sv
  - hdl/cpu_system.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/cpu_system_tb.sv

/* tb/cpu_program.svh */
`ifndef CPU_PROGRAM_SVH
`define CPU_PROGRAM_SVH

// reference alu, flags come back as {c, n, v, z}
function automatic cpu_pkg::ccr_t model_alu(input cpu_pkg::alu_func_t f,
    input cpu_pkg::word_t a, input cpu_pkg::word_t b, output cpu_pkg::word_t r);
  int s;
  int amt;
  logic c;
  logic v;
  amt = int'(b[3:0]);
  s = 0;
  c = 1'b0;
  r = '0;
  case (f)
    cpu_pkg::ALU_ADD: begin
      r = a + b;
      c = (int'(a) + int'(b)) > 65535;
      s = int'($signed(a)) + int'($signed(b));
    end
    cpu_pkg::ALU_SUB: begin
      r = a - b;
      c = a < b; // unsigned borrow
      s = int'($signed(a)) - int'($signed(b));
    end
    cpu_pkg::ALU_AND: r = a & b;
    cpu_pkg::ALU_OR:  r = a | b;
    cpu_pkg::ALU_XOR: r = a ^ b;
    cpu_pkg::ALU_SHL: begin
      r = a << amt;
      c = (amt != 0) && a[16 - amt]; // last bit pushed out the top
    end
    cpu_pkg::ALU_SHR: begin
      r = a >> amt;
      c = (amt != 0) && a[amt - 1];
    end
    default: r = '0;
  endcase
  v = (s > 32767) || (s < -32768); // s stays 0 unless add or sub
  return {c, r[15], v, r == '0};
endfunction

task automatic emit(input cpu_pkg::word_t w);
  prog.push_back(w);
endtask

task automatic put_ldi(input cpu_pkg::reg_addr_t rd, input cpu_pkg::word_t imm);
  emit({cpu_pkg::OPC_TWO_WORD, cpu_pkg::SUB_LDI, 5'd0, rd});
  emit(imm);
  if (live) model_regs[rd] = imm;
endtask

// register-register form, cmp only touches the model ccr
task automatic put_alu(input logic [3:0] sub, input cpu_pkg::alu_func_t f,
                       input cpu_pkg::reg_addr_t rd, rs1, rs2);
  cpu_pkg::word_t r;
  cpu_pkg::ccr_t flags;
  emit({cpu_pkg::OPC_TWO_WORD, sub, 1'b0, f, rd});
  emit({6'd0, rs1, rs2});
  flags = model_alu(f, model_regs[rs1], model_regs[rs2], r);
  if (live && sub == cpu_pkg::SUB_CMP) model_ccr = flags;
  if (live && sub == cpu_pkg::SUB_ALU) model_regs[rd] = r;
endtask

task automatic put_mem(input logic [1:0] sub, input cpu_pkg::reg_addr_t r,
                       input cpu_pkg::addr_t a);
  emit({cpu_pkg::OPC_THREE_WORD, sub, 7'd0, r});
  emit(a[31:16]); // high half first
  emit(a[15:0]);
  if (live && sub == cpu_pkg::MEM_LOAD) model_regs[r] = model_mem[a];
  if (live && sub == cpu_pkg::MEM_STORE) begin
    model_mem[a] = model_regs[r];
    exp_addr.push_back(a);
    exp_data.push_back(model_regs[r]);
    exp_ccr.push_back(model_ccr);
  end
endtask

task automatic put_store(input cpu_pkg::reg_addr_t r);
  put_mem(cpu_pkg::MEM_STORE, r, DATA_BASE + next_slot);
  next_slot++; // every store gets a fresh slot
endtask

task automatic put_marker(input cpu_pkg::word_t value);
  put_ldi(5'd31, value);
  put_store(5'd31);
endtask

task automatic put_branch(input logic [3:0] sub, output int at);
  at = prog.size();
  emit({cpu_pkg::OPC_TWO_WORD, sub, 10'd0});
  emit('0);
endtask

// offset counts from the word after the branch
task automatic aim_branch(input int at, input int target);
  prog[at + 1] = 16'(target - at - 2);
endtask

task automatic start_program();
  prog.delete();
  exp_addr.delete();
  exp_data.delete();
  exp_ccr.delete();
  foreach (model_regs[i]) model_regs[i] = '0;
  model_ccr = '0;
  live = 1'b1;
endtask

task automatic build_ldi_store();
  cpu_pkg::reg_addr_t r;
  repeat (6) begin
    r = 5'($urandom);
    put_ldi(r, 16'($urandom));
    put_store(r);
  end
endtask

task automatic build_alu();
  cpu_pkg::reg_addr_t rd;
  cpu_pkg::reg_addr_t rs1;
  cpu_pkg::reg_addr_t rs2;
  for (int f = 0; f < 8; f++) begin
    rd = 5'($urandom);
    rs1 = 5'($urandom);
    rs2 = 5'($urandom);
    put_ldi(rs1, 16'($urandom));
    put_ldi(rs2, 16'($urandom));
    put_alu(cpu_pkg::SUB_ALU, (f == 7) ? 4'd9 : 4'(f), rd, rs1, rs2); // 9 is undefined
    put_store(rd);
  end
endtask

task automatic build_cmp();
  cpu_pkg::word_t a;
  cpu_pkg::word_t b;
  for (int i = 0; i < 8; i++) begin
    a = (i == 2) ? 16'h8000 : 16'($urandom);
    b = (i < 2) ? a : ((i == 2) ? 16'h0001 : 16'($urandom)); // equal pairs, then overflow
    put_ldi(5'd1, a);
    put_ldi(5'd2, b);
    put_alu(cpu_pkg::SUB_CMP, cpu_pkg::ALU_SUB, 5'd0, 5'd1, 5'd2);
    put_store(5'd1);
  end
endtask

// one forward and one backward use of the same branch
task automatic branch_pair(input logic [3:0] sub, input logic zero);
  int at0;
  int at1;
  int at2;
  int back;
  logic taken;
  put_ldi(5'd1, 16'h0055);
  put_ldi(5'd2, zero ? 16'h0055 : 16'h0056);
  put_alu(cpu_pkg::SUB_CMP, cpu_pkg::ALU_SUB, 5'd0, 5'd1, 5'd2);
  taken = (sub == cpu_pkg::SUB_BRA) || (sub == cpu_pkg::SUB_BEQ && model_ccr[0]) ||
          (sub == cpu_pkg::SUB_BNE && !model_ccr[0]);
  put_branch(sub, at0);
  live = !taken;
  put_marker(16'hdead); // only reached when not taken
  live = 1'b1;
  aim_branch(at0, prog.size());
  put_marker(16'h0f0f);
  put_branch(cpu_pkg::SUB_BRA, at0);
  back = prog.size();
  live = taken;
  put_marker(16'hb0b0); // reached from the backward branch
  put_branch(cpu_pkg::SUB_BRA, at1);
  live = 1'b1;
  aim_branch(at0, prog.size());
  put_branch(sub, at2);
  aim_branch(at2, back);
  aim_branch(at1, prog.size());
  put_marker(16'hf00d);
endtask

task automatic build_branches();
  branch_pair(cpu_pkg::SUB_BRA, 1'b0);
  branch_pair(cpu_pkg::SUB_BEQ, 1'b1);
  branch_pair(cpu_pkg::SUB_BEQ, 1'b0);
  branch_pair(cpu_pkg::SUB_BNE, 1'b0);
  branch_pair(cpu_pkg::SUB_BNE, 1'b1);
endtask

task automatic build_jump_load();
  int at;
  int slot;
  put_ldi(5'd5, 16'($urandom));
  slot = next_slot;
  put_store(5'd5);
  at = prog.size();
  put_mem(cpu_pkg::MEM_JMP, 5'd0, BOOT_ADDR);
  live = 1'b0;
  put_marker(16'hdead); // jumped over
  live = 1'b1;
  prog[at + 2] = BOOT_ADDR[15:0] + 16'(prog.size());
  put_mem(cpu_pkg::MEM_LOAD, 5'd7, DATA_BASE + slot);
  put_store(5'd7);
endtask

task automatic build_halt(input int kind);
  put_marker(16'h1234);
  case (kind)
    0: emit({2'b01, 14'd0});
    1: emit({2'b00, 14'd0});
    default: put_mem(cpu_pkg::MEM_CALL, 5'd0, BOOT_ADDR);
  endcase
  live = 1'b0;
  put_marker(16'hbad0); // must never be written
  live = 1'b1;
endtask

`endif

/* tb/cpu_system_tb.sv */
`timescale 1ns/1ps

module cpu_system_tb;

  localparam cpu_pkg::addr_t BOOT_ADDR = 32'hff00_0000;
  localparam cpu_pkg::addr_t DATA_BASE = 32'h00a5_0200; // aliases to word 512 and up
  localparam int MEM_WORDS = 1024;
  localparam int NUM_RUNS = 8;
  localparam int CYCLES_PER_RUN = 2000;

  logic           clk;
  logic           rst_n;
  logic           prog_we;
  cpu_pkg::addr_t prog_addr;
  cpu_pkg::word_t prog_data;
  cpu_pkg::addr_t addrbus;
  cpu_pkg::word_t data_out;
  logic           write_out;
  cpu_pkg::ccr_t  ccr;
  logic           halted;

  cpu_pkg::word_t prog[$];
  cpu_pkg::addr_t exp_addr[$];
  cpu_pkg::word_t exp_data[$];
  cpu_pkg::ccr_t  exp_ccr[$];
  cpu_pkg::word_t model_mem[cpu_pkg::addr_t];
  cpu_pkg::word_t model_regs[32];
  cpu_pkg::ccr_t  model_ccr;
  logic           live;         // instructions being built will execute
  int             next_slot = 0;
  int             errors = 0;
  int             passed = 0;
  int             failed = 0;
  logic           halt_seen = 1'b0;
  string          current_test = "none";
  string          test_names[NUM_RUNS] = '{"ldi_store", "alu", "cmp", "branches",
                                           "jump_load", "halt_class01", "halt_class00",
                                           "halt_call"};

  `include "cpu_program.svh"

  cpu_system #(.BOOT_ADDR(BOOT_ADDR), .MEM_WORDS(MEM_WORDS)) u_cpu_system (
    .clk(clk), .rst_n(rst_n), .prog_we(prog_we), .prog_addr(prog_addr),
    .prog_data(prog_data), .addrbus(addrbus), .data_out(data_out),
    .write_out(write_out), .ccr(ccr), .halted(halted)
  );

  always #5 clk = ~clk;

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, want);
    errors++;
  endtask

  task automatic report_problem(input string what);
    $display("error at %0t in %s: %s", $time, current_test, what);
    errors++;
  endtask

  // outputs are sampled mid-cycle
  always @(negedge clk) begin
    if (!rst_n) begin
      halt_seen = 1'b0;
    end else begin
      if (write_out) begin
        assert (!halt_seen) else report_problem("write_out went high after halt");
        assert (exp_addr.size() > 0) else report_problem("store that was not expected");
        if (exp_addr.size() > 0) begin
          assert (addrbus == exp_addr[0]) else report_mismatch("addrbus", addrbus, exp_addr[0]);
          assert (data_out == exp_data[0]) else report_mismatch("data_out", data_out, exp_data[0]);
          assert (ccr == exp_ccr[0]) else report_mismatch("ccr", ccr, exp_ccr[0]);
          void'(exp_addr.pop_front());
          void'(exp_data.pop_front());
          void'(exp_ccr.pop_front());
        end
      end
      if (halt_seen) begin
        assert (halted) else report_problem("halted dropped before reset");
      end
      halt_seen = halt_seen | halted;
    end
  end

  task automatic run_program(input int t);
    int errors_before;
    errors_before = errors;
    current_test = test_names[t];
    emit(16'h0000); // invalid opcode ends every program
    @(posedge clk);
    rst_n <= 1'b0;
    foreach (prog[i]) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= i;
      prog_data <= prog[i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    while (!halted) @(negedge clk);
    repeat (20) @(negedge clk); // halt must stay quiet
    assert (exp_addr.size() == 0) else report_problem("expected stores never happened");
    if (errors == errors_before) begin
      passed++;
      $display("test %s: pass", current_test);
    end else begin
      failed++;
      $display("test %s: fail with %0d errors", current_test, errors - errors_before);
    end
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    void'($urandom(26));
    for (int t = 0; t < NUM_RUNS; t++) begin
      start_program();
      case (t)
        0: build_ldi_store();
        1: build_alu();
        2: build_cmp();
        3: build_branches();
        4: build_jump_load();
        default: build_halt(t - 5);
      endcase
      run_program(t);
    end
    $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    repeat (NUM_RUNS * CYCLES_PER_RUN) @(posedge clk);
    $display("timeout: test %s never reached halt", current_test);
    $display("Something failed");
    $finish;
  end

endmodule

/* hdl/cpu_system.sv */
`timescale 1ns/1ps

module cpu_system #(
  parameter cpu_pkg::addr_t BOOT_ADDR = 32'hff00_0000,
  parameter int             MEM_WORDS = 1024
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           prog_we,
  input  cpu_pkg::addr_t prog_addr,
  input  cpu_pkg::word_t prog_data,
  output cpu_pkg::addr_t addrbus,
  output cpu_pkg::word_t data_out,
  output logic           write_out,
  output cpu_pkg::ccr_t  ccr,
  output logic           halted
);

  cpu_pkg::word_t     data_in;
  cpu_pkg::word_t     reg_data1;
  cpu_pkg::word_t     reg_data2;
  cpu_pkg::reg_addr_t rd_addr1;
  cpu_pkg::reg_addr_t rd_addr2;
  cpu_pkg::reg_addr_t wr_addr;
  cpu_pkg::word_t     wr_data;
  logic               wr_en;
  cpu_pkg::word_t     alu_in1;
  cpu_pkg::word_t     alu_in2;
  cpu_pkg::alu_func_t alu_func;
  cpu_pkg::word_t     alu_result;
  logic               alu_carry;
  logic               alu_negative;
  logic               alu_overflow;
  logic               alu_zero;

  cpu_control #(.BOOT_ADDR(BOOT_ADDR)) u_cpu_control (
    .clk(clk), .rst_n(rst_n), .data_in(data_in),
    .reg_data1(reg_data1), .reg_data2(reg_data2),
    .alu_result(alu_result), .alu_carry(alu_carry), .alu_negative(alu_negative),
    .alu_overflow(alu_overflow), .alu_zero(alu_zero),
    .addrbus(addrbus), .data_out(data_out), .write_out(write_out),
    .ccr(ccr), .halted(halted),
    .rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
    .wr_addr(wr_addr), .wr_data(wr_data), .wr_en(wr_en),
    .alu_in1(alu_in1), .alu_in2(alu_in2), .alu_func(alu_func)
  );

  register_file u_register_file (
    .clk(clk), .rst_n(rst_n), .rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
    .wr_addr(wr_addr), .wr_data(wr_data), .wr_en(wr_en),
    .rd_data1(reg_data1), .rd_data2(reg_data2)
  );

  alu u_alu (
    .in1(alu_in1), .in2(alu_in2), .func(alu_func), .result(alu_result),
    .carry(alu_carry), .negative(alu_negative), .overflow(alu_overflow), .zero(alu_zero)
  );

  monitor_memory #(.MEM_WORDS(MEM_WORDS)) u_monitor_memory (
    .clk(clk), .addr(addrbus), .wdata(data_out), .we(write_out),
    .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
    .rdata(data_in)
  );

endmodule

/* hdl/monitor_memory.sv */
`timescale 1ns/1ps

module monitor_memory #(
  parameter int MEM_WORDS = 1024
) (
  input  logic           clk,
  input  cpu_pkg::addr_t addr,
  input  cpu_pkg::word_t wdata,
  input  logic           we,
  input  logic           prog_we,
  input  cpu_pkg::addr_t prog_addr,
  input  cpu_pkg::word_t prog_data,
  output cpu_pkg::word_t rdata
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  cpu_pkg::word_t mem [MEM_WORDS];

  logic [IDX_W-1:0] idx;      // upper address bits alias
  logic [IDX_W-1:0] prog_idx;

  assign idx      = addr[IDX_W-1:0];
  assign prog_idx = prog_addr[IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_idx] <= prog_data; // loader wins over the core
    end else if (we) begin
      mem[idx] <= wdata;
    end
    rdata <= mem[idx]; // one cycle read latency
  end

endmodule

/* hdl/cpu_control.sv */
`timescale 1ns/1ps

module cpu_control #(
  parameter cpu_pkg::addr_t BOOT_ADDR = 32'hff00_0000
) (
  input  logic               clk,
  input  logic               rst_n,
  input  cpu_pkg::word_t     data_in,
  input  cpu_pkg::word_t     reg_data1,
  input  cpu_pkg::word_t     reg_data2,
  input  cpu_pkg::word_t     alu_result,
  input  logic               alu_carry,
  input  logic               alu_negative,
  input  logic               alu_overflow,
  input  logic               alu_zero,
  output cpu_pkg::addr_t     addrbus,
  output cpu_pkg::word_t     data_out,
  output logic               write_out,
  output cpu_pkg::ccr_t      ccr,
  output logic               halted,
  output cpu_pkg::reg_addr_t rd_addr1,
  output cpu_pkg::reg_addr_t rd_addr2,
  output cpu_pkg::reg_addr_t wr_addr,
  output cpu_pkg::word_t     wr_data,
  output logic               wr_en,
  output cpu_pkg::word_t     alu_in1,
  output cpu_pkg::word_t     alu_in2,
  output cpu_pkg::alu_func_t alu_func
);

  cpu_pkg::cpu_state_e state, state_next;
  cpu_pkg::addr_t      pc, pc_next;
  cpu_pkg::addr_t      mar, mar_next;     // operand address
  cpu_pkg::word_t      opcode, opcode_next;
  cpu_pkg::word_t      data_out_next;
  cpu_pkg::ccr_t       ccr_next;
  cpu_pkg::addr_t      branch_target;

  // the second word is on data_in in FETCH2, pc still points at it
  assign branch_target = pc + 32'd1 + {{16{data_in[15]}}, data_in};

  assign addrbus = (state == cpu_pkg::STORE || state == cpu_pkg::LOADW ||
                    state == cpu_pkg::LOAD) ? mar : pc;
  assign write_out = (state == cpu_pkg::STORE);
  assign halted    = (state == cpu_pkg::HALT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= cpu_pkg::FETCH1W;
      pc       <= BOOT_ADDR;
      mar      <= '0;
      opcode   <= '0;
      data_out <= '0;
      ccr      <= '0;
    end else begin
      state    <= state_next;
      pc       <= pc_next;
      mar      <= mar_next;
      opcode   <= opcode_next;
      data_out <= data_out_next;
      ccr      <= ccr_next;
    end
  end

  always_comb begin
    state_next    = state;
    pc_next       = pc;
    mar_next      = mar;
    opcode_next   = opcode;
    data_out_next = data_out;
    ccr_next      = ccr;
    rd_addr1      = '0;
    rd_addr2      = '0;
    wr_addr       = '0;
    wr_data       = '0;
    wr_en         = 1'b0;
    alu_in1       = '0;
    alu_in2       = '0;
    alu_func      = cpu_pkg::ALU_ADD;

    case (state)
      cpu_pkg::FETCH1W: state_next = cpu_pkg::FETCH1;
      cpu_pkg::FETCH1: begin
        pc_next     = pc + 32'd1;
        opcode_next = data_in;
        case (data_in[15:14])
          cpu_pkg::OPC_THREE_WORD: state_next = cpu_pkg::MEMOP1W;
          cpu_pkg::OPC_TWO_WORD:   state_next = cpu_pkg::FETCH2W;
          default:                 state_next = cpu_pkg::HALT; // classes 01, 00
        endcase
      end
      cpu_pkg::FETCH2W: state_next = cpu_pkg::FETCH2;
      cpu_pkg::FETCH2: begin
        pc_next    = pc + 32'd1;
        state_next = cpu_pkg::FETCH1W;
        case (opcode[13:10])
          cpu_pkg::SUB_CMP: begin
            rd_addr1 = data_in[9:5];
            rd_addr2 = data_in[4:0];
            alu_in1  = reg_data1;
            alu_in2  = reg_data2;
            alu_func = opcode[8:5];
            ccr_next = {alu_carry, alu_negative, alu_overflow, alu_zero};
          end
          cpu_pkg::SUB_LDI: begin
            wr_addr = opcode[4:0];
            wr_data = data_in; // immediate is the second word
            wr_en   = 1'b1;
          end
          cpu_pkg::SUB_BRA: pc_next = branch_target;
          cpu_pkg::SUB_BEQ: begin
            if (ccr[cpu_pkg::CCR_ZERO]) begin
              pc_next = branch_target;
            end
          end
          cpu_pkg::SUB_BNE: begin
            if (!ccr[cpu_pkg::CCR_ZERO]) begin
              pc_next = branch_target;
            end
          end
          cpu_pkg::SUB_ALU: begin
            rd_addr1 = data_in[9:5];
            rd_addr2 = data_in[4:0];
            alu_in1  = reg_data1;
            alu_in2  = reg_data2;
            alu_func = opcode[8:5];
            wr_addr  = opcode[4:0];
            wr_data  = alu_result;
            wr_en    = 1'b1;
          end
          default: state_next = cpu_pkg::HALT; // undefined sub-opcode
        endcase
      end
      cpu_pkg::MEMOP1W: state_next = cpu_pkg::MEMOP1;
      cpu_pkg::MEMOP1: begin
        pc_next         = pc + 32'd1;
        mar_next[31:16] = data_in; // second word is the high half
        state_next      = cpu_pkg::MEMOP2W;
      end
      cpu_pkg::MEMOP2W: state_next = cpu_pkg::MEMOP2;
      cpu_pkg::MEMOP2: begin
        pc_next        = pc + 32'd1;
        mar_next[15:0] = data_in;
        case (opcode[13:12])
          cpu_pkg::MEM_LOAD: state_next = cpu_pkg::LOADW;
          cpu_pkg::MEM_STORE: begin
            rd_addr1      = opcode[4:0];
            data_out_next = reg_data1;
            state_next    = cpu_pkg::STORE;
          end
          cpu_pkg::MEM_JMP: begin
            pc_next    = {mar[31:16], data_in};
            state_next = cpu_pkg::FETCH1W;
          end
          cpu_pkg::MEM_CALL: state_next = cpu_pkg::HALT; // no stack
          default:           state_next = cpu_pkg::HALT;
        endcase
      end
      cpu_pkg::STORE: state_next = cpu_pkg::FETCH1W;
      cpu_pkg::LOADW: state_next = cpu_pkg::LOAD; // memory sees mar here
      cpu_pkg::LOAD: begin
        wr_addr    = opcode[4:0];
        wr_data    = data_in;
        wr_en      = 1'b1;
        state_next = cpu_pkg::FETCH1W;
      end
      cpu_pkg::HALT: state_next = cpu_pkg::HALT; // only reset leaves
      default:       state_next = cpu_pkg::HALT;
    endcase
  end

endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ps

module register_file (
  input  logic               clk,
  input  logic               rst_n,
  input  cpu_pkg::reg_addr_t rd_addr1,
  input  cpu_pkg::reg_addr_t rd_addr2,
  input  cpu_pkg::reg_addr_t wr_addr,
  input  cpu_pkg::word_t     wr_data,
  input  logic               wr_en,
  output cpu_pkg::word_t     rd_data1,
  output cpu_pkg::word_t     rd_data2
);

  cpu_pkg::word_t regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // combinational reads, a write shows up after the edge
  assign rd_data1 = regs[rd_addr1];
  assign rd_data2 = regs[rd_addr2];

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
  input  cpu_pkg::word_t     in1,
  input  cpu_pkg::word_t     in2,
  input  cpu_pkg::alu_func_t func,
  output cpu_pkg::word_t     result,
  output logic               carry,
  output logic               negative,
  output logic               overflow,
  output logic               zero
);

  logic [16:0] wide; // result with one extra bit for carry or borrow

  always_comb begin
    wide     = '0;
    result   = '0;
    carry    = 1'b0;
    overflow = 1'b0;
    case (func)
      cpu_pkg::ALU_ADD: begin
        wide     = {1'b0, in1} + {1'b0, in2};
        result   = wide[15:0];
        carry    = wide[16];
        overflow = (in1[15] == in2[15]) && (result[15] != in1[15]);
      end
      cpu_pkg::ALU_SUB: begin
        wide     = {1'b0, in1} - {1'b0, in2};
        result   = wide[15:0];
        carry    = wide[16]; // set when in1 < in2 unsigned
        overflow = (in1[15] != in2[15]) && (result[15] != in1[15]);
      end
      cpu_pkg::ALU_AND: begin
        result = in1 & in2;
      end
      cpu_pkg::ALU_OR: begin
        result = in1 | in2;
      end
      cpu_pkg::ALU_XOR: begin
        result = in1 ^ in2;
      end
      cpu_pkg::ALU_SHL: begin
        // shift amount from low nibble of in2, carry is last bit out
        wide   = {1'b0, in1} << in2[3:0];
        result = wide[15:0];
        carry  = wide[16];
      end
      cpu_pkg::ALU_SHR: begin
        wide   = {in1, 1'b0} >> in2[3:0];
        result = wide[16:1];
        carry  = wide[0];
      end
      default: begin
        result = '0; // undefined codes
      end
    endcase
  end

  assign negative = result[15];
  assign zero     = (result == '0);

endmodule

/* hdl/cpu_pkg.sv */
package cpu_pkg;

  typedef logic [15:0] word_t;     // data word, register value, alu operand
  typedef logic [31:0] addr_t;     // word address, no byte lanes
  typedef logic [4:0]  reg_addr_t; // register number
  typedef logic [3:0]  alu_func_t; // alu function code
  typedef logic [3:0]  ccr_t;      // {carry, negative, overflow, zero}

  // bit position of zero in ccr, tested by beq and bne
  localparam int CCR_ZERO = 0;

  localparam alu_func_t ALU_ADD = 4'd0;
  localparam alu_func_t ALU_SUB = 4'd1;
  localparam alu_func_t ALU_AND = 4'd2;
  localparam alu_func_t ALU_OR  = 4'd3;
  localparam alu_func_t ALU_XOR = 4'd4;
  localparam alu_func_t ALU_SHL = 4'd5;
  localparam alu_func_t ALU_SHR = 4'd6;

  // instruction class, bits 15:14 of the first word
  localparam logic [1:0] OPC_THREE_WORD = 2'b11;
  localparam logic [1:0] OPC_TWO_WORD   = 2'b10;

  // two-word sub-opcodes, bits 13:10
  localparam logic [3:0] SUB_CMP = 4'b0000;
  localparam logic [3:0] SUB_LDI = 4'b1000;
  localparam logic [3:0] SUB_BRA = 4'b1001;
  localparam logic [3:0] SUB_BEQ = 4'b1010;
  localparam logic [3:0] SUB_BNE = 4'b1100;
  localparam logic [3:0] SUB_ALU = 4'b1101;

  // three-word sub-opcodes, bits 13:12
  localparam logic [1:0] MEM_LOAD  = 2'b11;
  localparam logic [1:0] MEM_STORE = 2'b10;
  localparam logic [1:0] MEM_JMP   = 2'b01;
  localparam logic [1:0] MEM_CALL  = 2'b00;

  typedef enum logic [3:0] {
    FETCH1W, FETCH1, FETCH2W, FETCH2,
    MEMOP1W, MEMOP1, MEMOP2W, MEMOP2,
    STORE, LOADW, LOAD, HALT
  } cpu_state_e;

endpackage
